/* design/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath and register-file geometry
`define XLEN          32
`define GPR_AW        5

// one bit per ALU function with positions named in id_pkg
`define ALU_OP_W      12

// branch condition code and immediate form selectors
`define BR_KIND_W     4
`define IMM_KIND_W    2

// bl always links through r1
`define LINK_REG      1

// return address offset added by bl and jirl
`define JUMP_LINK_INC 4

`endif

/* design/id_pkg.sv */
`default_nettype none
`include "id_settings.svh"

package id_pkg;

    typedef struct packed {
        logic [16:0]        opcode;
        logic [`GPR_AW-1:0] rk;
        logic [`GPR_AW-1:0] rj;
        logic [`GPR_AW-1:0] rd;
    } reg3_fmt_t;

    typedef struct packed {
        logic [9:0]         opcode;
        logic [11:0]        i12;
        logic [`GPR_AW-1:0] rj;
        logic [`GPR_AW-1:0] rd;
    } imm12_fmt_t;

    typedef struct packed {
        logic [5:0]         opcode;
        logic [15:0]        i16;
        logic [`GPR_AW-1:0] rj;
        logic [`GPR_AW-1:0] rd;
    } imm16_fmt_t;

    typedef struct packed {
        logic [6:0]         opcode;
        logic [19:0]        i20;
        logic [`GPR_AW-1:0] rd;
    } imm20_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi; // upper offset bits sit below the low ones in the word
    } imm26_fmt_t;

    typedef union packed {
        reg3_fmt_t  reg3_fmt;
        imm12_fmt_t imm12_fmt;
        imm16_fmt_t imm16_fmt;
        imm20_fmt_t imm20_fmt;
        imm26_fmt_t imm26_fmt;
    } inst_word_u;

    localparam int alu_op_add  = 0;
    localparam int alu_op_sub  = 1;
    localparam int alu_op_slt  = 2;
    localparam int alu_op_sltu = 3;
    localparam int alu_op_and  = 4;
    localparam int alu_op_nor  = 5;
    localparam int alu_op_or   = 6;
    localparam int alu_op_xor  = 7;
    localparam int alu_op_sll  = 8;
    localparam int alu_op_srl  = 9;
    localparam int alu_op_sra  = 10;
    localparam int alu_op_lui  = 11;

    localparam logic [`BR_KIND_W-1:0] br_kind_none = 'd0;
    localparam logic [`BR_KIND_W-1:0] br_kind_eq   = 'd1;
    localparam logic [`BR_KIND_W-1:0] br_kind_ne   = 'd2;
    localparam logic [`BR_KIND_W-1:0] br_kind_lt   = 'd3;
    localparam logic [`BR_KIND_W-1:0] br_kind_ge   = 'd4;
    localparam logic [`BR_KIND_W-1:0] br_kind_ltu  = 'd5;
    localparam logic [`BR_KIND_W-1:0] br_kind_geu  = 'd6;
    localparam logic [`BR_KIND_W-1:0] br_kind_pc   = 'd7; // b and bl are always taken
    localparam logic [`BR_KIND_W-1:0] br_kind_jirl = 'd8;

    localparam logic [`IMM_KIND_W-1:0] imm_kind_si12  = 'd0;
    localparam logic [`IMM_KIND_W-1:0] imm_kind_ui12  = 'd1;
    localparam logic [`IMM_KIND_W-1:0] imm_kind_u20   = 'd2;
    localparam logic [`IMM_KIND_W-1:0] imm_kind_link4 = 'd3;

endpackage

`default_nettype wire

/* design/inst_decoder.sv */
`default_nettype none
`timescale 1ns/1ps
`include "id_settings.svh"

module inst_decoder (
    input  id_pkg::inst_word_u     inst,
    output logic [`ALU_OP_W-1:0]   alu_op,
    output logic                   src1_is_pc,
    output logic                   src2_is_imm,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic [1:0]             mem_size,
    output logic                   mem_signed,
    output logic                   gr_we,
    output logic [`GPR_AW-1:0]     dest,
    output logic                   rj_used,
    output logic                   rkd_used,
    output logic [`GPR_AW-1:0]     rf_raddr1,
    output logic [`GPR_AW-1:0]     rf_raddr2,
    output logic [`BR_KIND_W-1:0]  br_kind,
    output logic [`IMM_KIND_W-1:0] imm_kind
);

    int unsigned alu_sel;
    logic        hit3;
    logic        hit12;
    logic        ui12;
    logic        fmt_r3;
    logic        fmt_ri;
    logic        is_lu12i;
    logic        is_pcadd;
    logic        mem_op;
    logic [3:0]  mem_sub;
    logic        is_ld;
    logic        is_st;
    logic        is_bl;
    logic        is_jirl;
    logic        is_cbr;

    always_comb begin
        alu_sel = id_pkg::alu_op_add; // loads, stores and links compute with add
        hit3    = 1'b1;
        hit12   = 1'b1;
        ui12    = 1'b0;
        case (inst.reg3_fmt.opcode)
            17'h00020: alu_sel = id_pkg::alu_op_add;
            17'h00022: alu_sel = id_pkg::alu_op_sub;
            17'h00024: alu_sel = id_pkg::alu_op_slt;
            17'h00025: alu_sel = id_pkg::alu_op_sltu;
            17'h00028: alu_sel = id_pkg::alu_op_nor;
            17'h00029: alu_sel = id_pkg::alu_op_and;
            17'h0002a: alu_sel = id_pkg::alu_op_or;
            17'h0002b: alu_sel = id_pkg::alu_op_xor;
            17'h0002e: alu_sel = id_pkg::alu_op_sll;
            17'h0002f: alu_sel = id_pkg::alu_op_srl;
            17'h00030: alu_sel = id_pkg::alu_op_sra;
            17'h00081: alu_sel = id_pkg::alu_op_sll; // shift amount rides in the rk slot
            17'h00089: alu_sel = id_pkg::alu_op_srl;
            17'h00091: alu_sel = id_pkg::alu_op_sra;
            default:   hit3 = 1'b0;
        endcase
        case (inst.imm12_fmt.opcode)
            10'h008: alu_sel = id_pkg::alu_op_slt;
            10'h009: alu_sel = id_pkg::alu_op_sltu;
            10'h00a: alu_sel = id_pkg::alu_op_add;
            10'h00d: begin
                alu_sel = id_pkg::alu_op_and;
                ui12    = 1'b1;
            end
            10'h00e: begin
                alu_sel = id_pkg::alu_op_or;
                ui12    = 1'b1;
            end
            10'h00f: begin
                alu_sel = id_pkg::alu_op_xor;
                ui12    = 1'b1;
            end
            default: hit12 = 1'b0;
        endcase
        if (is_lu12i) begin
            alu_sel = id_pkg::alu_op_lui;
        end
    end

    always_comb begin
        case (inst.imm16_fmt.opcode)
            6'h13:   br_kind = id_pkg::br_kind_jirl;
            6'h14:   br_kind = id_pkg::br_kind_pc;
            6'h15:   br_kind = id_pkg::br_kind_pc;
            6'h16:   br_kind = id_pkg::br_kind_eq;
            6'h17:   br_kind = id_pkg::br_kind_ne;
            6'h18:   br_kind = id_pkg::br_kind_lt;
            6'h19:   br_kind = id_pkg::br_kind_ge;
            6'h1a:   br_kind = id_pkg::br_kind_ltu;
            6'h1b:   br_kind = id_pkg::br_kind_geu;
            default: br_kind = id_pkg::br_kind_none;
        endcase
    end

    // register ops sit at 0x20..0x30 and the shift-immediate forms above 0x80
    assign fmt_r3   = hit3 & ~inst.reg3_fmt.opcode[7];
    assign fmt_ri   = (hit3 & inst.reg3_fmt.opcode[7]) | hit12;
    assign is_lu12i = inst.imm20_fmt.opcode == 7'h0a;
    assign is_pcadd = inst.imm20_fmt.opcode == 7'h0e;
    assign is_bl    = inst.imm16_fmt.opcode == 6'h15;
    assign is_jirl  = br_kind == id_pkg::br_kind_jirl;
    assign is_cbr   = br_kind inside {id_pkg::br_kind_eq, id_pkg::br_kind_ne,
                                      id_pkg::br_kind_lt, id_pkg::br_kind_ge,
                                      id_pkg::br_kind_ltu, id_pkg::br_kind_geu};

    // low nibble of the memory opcode holds size, store and unsigned bits
    assign mem_sub  = inst.imm12_fmt.opcode[3:0];
    assign mem_op   = inst.imm12_fmt.opcode[9:4] == 6'h0a &&
                      mem_sub inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h8, 4'h9};
    assign is_ld    = mem_op & ~mem_sub[2];
    assign is_st    = mem_op & mem_sub[2];

    assign mem_read   = is_ld;
    assign mem_write  = is_st;
    assign mem_size   = mem_op ? mem_sub[1:0] : 2'd0; // 0 byte, 1 half, 2 word
    assign mem_signed = is_ld & ~mem_sub[3];

    assign gr_we       = fmt_r3 | fmt_ri | is_lu12i | is_pcadd | is_ld | is_bl | is_jirl;
    assign src1_is_pc  = is_pcadd | is_bl | is_jirl;
    assign src2_is_imm = fmt_ri | is_lu12i | is_pcadd | mem_op | is_bl | is_jirl;
    assign rj_used     = fmt_r3 | fmt_ri | mem_op | is_cbr | is_jirl;
    assign rkd_used    = fmt_r3 | is_st | is_cbr;

    assign imm_kind = (is_bl | is_jirl)      ? id_pkg::imm_kind_link4 :
                      (is_lu12i | is_pcadd)  ? id_pkg::imm_kind_u20   :
                      ui12                   ? id_pkg::imm_kind_ui12  :
                                               id_pkg::imm_kind_si12;

    always_comb begin
        alu_op = '0;
        if (gr_we | is_st) begin
            alu_op[alu_sel] = 1'b1;
        end
    end

    // stores and conditional branches compare or store rd
    assign rf_raddr1 = inst.reg3_fmt.rj;
    assign rf_raddr2 = (is_st | is_cbr) ? inst.reg3_fmt.rd : inst.reg3_fmt.rk;

    assign dest = !gr_we ? '0 :
                  is_bl  ? `GPR_AW'(`LINK_REG) :
                           inst.reg3_fmt.rd;

endmodule

`default_nettype wire

/* design/imm_gen.sv */
`default_nettype none
`timescale 1ns/1ps
`include "id_settings.svh"

module imm_gen (
    input  id_pkg::inst_word_u     inst,
    input  logic [`IMM_KIND_W-1:0] imm_kind,
    output logic [`XLEN-1:0]       imm,
    output logic [`XLEN-1:0]       br_offs,
    output logic [`XLEN-1:0]       jirl_offs
);

    logic [11:0] i12;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        long_jump;

    assign i12 = inst.imm12_fmt.i12;
    assign i16 = inst.imm16_fmt.i16;
    assign i26 = {inst.imm26_fmt.offs_hi, inst.imm26_fmt.offs_lo};

    // b and bl are the only words that carry the 26-bit offset
    assign long_jump = inst.imm26_fmt.opcode[5:1] == 5'b01010;

    always_comb begin
        case (imm_kind)
            id_pkg::imm_kind_link4: imm = `XLEN'(`JUMP_LINK_INC);
            id_pkg::imm_kind_u20:   imm = {inst.imm20_fmt.i20, {(`XLEN-20){1'b0}}};
            id_pkg::imm_kind_ui12:  imm = {{(`XLEN-12){1'b0}}, i12};
            default:                imm = {{(`XLEN-12){i12[11]}}, i12};
        endcase
    end

    assign jirl_offs = {{(`XLEN-18){i16[15]}}, i16, 2'b00};
    assign br_offs   = long_jump ? {{(`XLEN-28){i26[25]}}, i26, 2'b00} : jirl_offs;

endmodule

`default_nettype wire

/* design/operand_bypass.sv */
`default_nettype none
`timescale 1ns/1ps
`include "id_settings.svh"

module operand_bypass (
    input  logic [`GPR_AW-1:0] rf_raddr1,
    input  logic [`GPR_AW-1:0] rf_raddr2,
    input  logic               rj_used,
    input  logic               rkd_used,
    input  logic [`XLEN-1:0]   rf_rdata1,
    input  logic [`XLEN-1:0]   rf_rdata2,
    input  logic [`GPR_AW-1:0] ex_dest,
    input  logic [`XLEN-1:0]   ex_value,
    input  logic               ex_is_load,
    input  logic [`GPR_AW-1:0] mem_dest,
    input  logic [`XLEN-1:0]   mem_value,
    input  logic               mem_wait,
    input  logic [`GPR_AW-1:0] wb_dest,
    input  logic [`XLEN-1:0]   wb_value,
    output logic [`XLEN-1:0]   rj_value,
    output logic [`XLEN-1:0]   rkd_value,
    output logic               stall
);

    // the youngest producer wins while r0 and unused sources read the file
    function automatic logic [`XLEN-1:0] pick (
        input logic [`GPR_AW-1:0] addr,
        input logic               used,
        input logic [`XLEN-1:0]   rdata
    );
        logic [`XLEN-1:0] value;
        value = rdata;
        if (used && addr != '0) begin
            if (addr == ex_dest) begin
                value = ex_value;
            end else if (addr == mem_dest) begin
                value = mem_value;
            end else if (addr == wb_dest) begin
                value = wb_value;
            end
        end
        return value;
    endfunction

    always_comb begin
        rj_value  = pick(rf_raddr1, rj_used, rf_rdata1);
        rkd_value = pick(rf_raddr2, rkd_used, rf_rdata2);
    end

    // an EX load has no data yet and MEM may still be waiting on memory
    assign stall = ex_is_load | mem_wait;

endmodule

`default_nettype wire

/* design/branch_unit.sv */
`default_nettype none
`timescale 1ns/1ps
`include "id_settings.svh"

module branch_unit (
    input  logic [`BR_KIND_W-1:0] br_kind,
    input  logic                  valid,
    input  logic                  stall,
    input  logic [`XLEN-1:0]      id_pc,
    input  logic [`XLEN-1:0]      rj_value,
    input  logic [`XLEN-1:0]      rkd_value,
    input  logic [`XLEN-1:0]      br_offs,
    input  logic [`XLEN-1:0]      jirl_offs,
    output logic                  br_taken,
    output logic [`XLEN-1:0]      br_target
);

    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    assign eq  = rj_value == rkd_value;
    assign lt  = $signed(rj_value) < $signed(rkd_value);
    assign ltu = rj_value < rkd_value;

    always_comb begin
        case (br_kind)
            id_pkg::br_kind_eq:   cond = eq;
            id_pkg::br_kind_ne:   cond = ~eq;
            id_pkg::br_kind_lt:   cond = lt;
            id_pkg::br_kind_ge:   cond = ~lt;
            id_pkg::br_kind_ltu:  cond = ltu;
            id_pkg::br_kind_geu:  cond = ~ltu;
            id_pkg::br_kind_pc,
            id_pkg::br_kind_jirl: cond = 1'b1;
            default:              cond = 1'b0;
        endcase
    end

    // a stalled compare may still see stale operands
    assign br_taken  = valid & ~stall & cond;
    assign br_target = (br_kind == id_pkg::br_kind_jirl) ? rj_value + jirl_offs
                                                         : id_pc + br_offs;

endmodule

`default_nettype wire

/* design/id_stage.sv */
`default_nettype none
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  if_valid,
    input  logic [`XLEN-1:0]      if_pc,
    input  logic [`XLEN-1:0]      if_inst,
    input  logic                  ex_allow_in,
    input  logic [`XLEN-1:0]      rf_rdata1,
    input  logic [`XLEN-1:0]      rf_rdata2,
    input  logic [`GPR_AW-1:0]    ex_dest,
    input  logic [`XLEN-1:0]      ex_value,
    input  logic                  ex_is_load,
    input  logic [`GPR_AW-1:0]    mem_dest,
    input  logic [`XLEN-1:0]      mem_value,
    input  logic                  mem_wait,
    input  logic [`GPR_AW-1:0]    wb_dest,
    input  logic [`XLEN-1:0]      wb_value,
    output logic                  id_allow_in,
    output logic                  id_to_ex_valid,
    output logic [`XLEN-1:0]      id_pc,
    output logic [`XLEN-1:0]      rj_value,
    output logic [`XLEN-1:0]      rkd_value,
    output logic [`XLEN-1:0]      imm,
    output logic [`ALU_OP_W-1:0]  alu_op,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic [1:0]            mem_size,
    output logic                  mem_signed,
    output logic [`GPR_AW-1:0]    dest,
    output logic                  gr_we,
    output logic                  br_taken,
    output logic [`XLEN-1:0]      br_target,
    output logic [`GPR_AW-1:0]    rf_raddr1,
    output logic [`GPR_AW-1:0]    rf_raddr2
);

    logic                   id_valid;
    id_pkg::inst_word_u     inst_r;
    logic                   hazard;
    logic                   stall;
    logic                   rj_used;
    logic                   rkd_used;
    logic [`BR_KIND_W-1:0]  br_kind;
    logic [`IMM_KIND_W-1:0] imm_kind;
    logic [`XLEN-1:0]       br_offs;
    logic [`XLEN-1:0]       jirl_offs;

    assign stall          = id_valid & hazard;
    assign id_allow_in    = ~id_valid | (~stall & ex_allow_in);
    assign id_to_ex_valid = id_valid & ~stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0; // the word behind a taken branch is on the wrong path
        end else if (id_allow_in) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allow_in) begin
            id_pc  <= if_pc;
            inst_r <= if_inst;
        end
    end

    inst_decoder u_decoder (
        .inst        (inst_r),
        .alu_op      (alu_op),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_size    (mem_size),
        .mem_signed  (mem_signed),
        .gr_we       (gr_we),
        .dest        (dest),
        .rj_used     (rj_used),
        .rkd_used    (rkd_used),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2),
        .br_kind     (br_kind),
        .imm_kind    (imm_kind)
    );

    imm_gen u_imm_gen (
        .inst      (inst_r),
        .imm_kind  (imm_kind),
        .imm       (imm),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs)
    );

    operand_bypass u_bypass (
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rj_used    (rj_used),
        .rkd_used   (rkd_used),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .ex_dest    (ex_dest),
        .ex_value   (ex_value),
        .ex_is_load (ex_is_load),
        .mem_dest   (mem_dest),
        .mem_value  (mem_value),
        .mem_wait   (mem_wait),
        .wb_dest    (wb_dest),
        .wb_value   (wb_value),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .stall      (hazard)
    );

    branch_unit u_branch (
        .br_kind   (br_kind),
        .valid     (id_valid),
        .stall     (stall),
        .id_pc     (id_pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

`default_nettype wire

/* verif/id_checker.sv */
`default_nettype none
`timescale 1ns/1ps
`include "id_settings.svh"

module id_checker (
    input  logic                 clk,
    input  logic [2:0]           mode,
    input  int                   vec_idx,
    input  logic [`XLEN-1:0]     exp_inst,
    input  logic [`XLEN-1:0]     exp_pc,
    input  logic [`ALU_OP_W-1:0] exp_alu_op,
    input  logic [7:0]           exp_ctl,
    input  logic [`XLEN-1:0]     exp_imm,
    input  logic [`GPR_AW-1:0]   exp_dest,
    input  logic [`XLEN-1:0]     exp_rj,
    input  logic [`XLEN-1:0]     exp_rkd,
    input  logic                 exp_taken,
    input  logic [`XLEN-1:0]     exp_target,
    input  logic                 id_allow_in,
    input  logic                 id_to_ex_valid,
    input  logic [`XLEN-1:0]     id_pc,
    input  logic [`XLEN-1:0]     rj_value,
    input  logic [`XLEN-1:0]     rkd_value,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`ALU_OP_W-1:0] alu_op,
    input  logic                 src1_is_pc,
    input  logic                 src2_is_imm,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic [1:0]           mem_size,
    input  logic                 mem_signed,
    input  logic [`GPR_AW-1:0]   dest,
    input  logic                 gr_we,
    input  logic                 br_taken,
    input  logic [`XLEN-1:0]     br_target,
    input  logic [`GPR_AW-1:0]   rf_raddr1,
    input  logic [`GPR_AW-1:0]   rf_raddr2,
    output int                   tests_run,
    output int                   tests_failed
);

    // mode codes driven by the testbench
    localparam logic [2:0] stall_phase   = 3'd1;
    localparam logic [2:0] hold_phase    = 3'd2;
    localparam logic [2:0] deliver_phase = 3'd3;
    localparam logic [2:0] after_phase   = 3'd4;

    int vec_errs;

    // stores and the six conditional branches name their second source in rd
    function automatic logic reads_rd(input logic [31:0] word, input logic is_store);
        return is_store || (word[31:26] >= 6'h16 && word[31:26] <= 6'h1b);
    endfunction

    task automatic expect_field(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %0d ns vector %0d: %s is %h, expected %h",
                     $time, vec_idx, name, got, want);
            vec_errs++;
        end
    endtask

    task automatic compare_fields();
        expect_field("id_pc", id_pc, exp_pc);
        expect_field("alu_op", 32'(alu_op), 32'(exp_alu_op));
        expect_field("control", {src1_is_pc, src2_is_imm, mem_read, mem_write,
                                 mem_size, mem_signed, gr_we}, 32'(exp_ctl));
        expect_field("dest", 32'(dest), 32'(exp_dest));
        expect_field("rj_value", rj_value, exp_rj);
        expect_field("rkd_value", rkd_value, exp_rkd);
        expect_field("rf_raddr1", 32'(rf_raddr1), 32'(exp_inst[9:5]));
        expect_field("rf_raddr2", 32'(rf_raddr2),
                     32'(reads_rd(exp_inst, exp_ctl[4]) ? exp_inst[4:0] : exp_inst[14:10]));
        expect_field("br_taken", 32'(br_taken), 32'(exp_taken));
        if (exp_ctl[6]) begin
            expect_field("imm", imm, exp_imm);
        end
        if (exp_taken) begin
            expect_field("br_target", br_target, exp_target);
        end
    endtask

    initial begin
        tests_run    = 0;
        tests_failed = 0;
        vec_errs     = 0;
    end

    // outputs are combinational and settle before the falling edge
    always @(negedge clk) begin
        case (mode)
            stall_phase: begin
                expect_field("id_to_ex_valid", 32'(id_to_ex_valid), 32'd0);
                expect_field("br_taken", 32'(br_taken), 32'd0);
                expect_field("id_allow_in", 32'(id_allow_in), 32'd0);
            end
            hold_phase: begin
                expect_field("id_to_ex_valid", 32'(id_to_ex_valid), 32'd1);
                expect_field("id_allow_in", 32'(id_allow_in), 32'd0);
                compare_fields();
            end
            deliver_phase: begin
                expect_field("id_to_ex_valid", 32'(id_to_ex_valid), 32'd1);
                expect_field("id_allow_in", 32'(id_allow_in), 32'd1);
                compare_fields();
            end
            after_phase: begin
                // a taken branch kills the word fetched behind it
                expect_field("id_to_ex_valid after", 32'(id_to_ex_valid), 32'(!exp_taken));
                tests_run++;
                if (vec_errs != 0) begin
                    tests_failed++;
                    $display("vector %0d failed with %0d mismatches", vec_idx, vec_errs);
                end else begin
                    $display("vector %0d ok", vec_idx);
                end
                vec_errs = 0;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verif/tb_id_stage.sv */
`default_nettype none
`timescale 1ns/1ps
`include "id_settings.svh"

module tb_id_stage;

    localparam int max_vecs = 64;
    localparam int ncols    = 21;

    logic clk, arst_n, if_valid, ex_allow_in, ex_is_load, mem_wait;
    logic [`XLEN-1:0] if_pc, if_inst, rf_rdata1, rf_rdata2, ex_value, mem_value, wb_value;
    logic [`GPR_AW-1:0] ex_dest, mem_dest, wb_dest;
    logic id_allow_in, id_to_ex_valid, src1_is_pc, src2_is_imm, mem_read, mem_write;
    logic mem_signed, gr_we, br_taken;
    logic [1:0] mem_size;
    logic [`XLEN-1:0] id_pc, rj_value, rkd_value, imm, br_target;
    logic [`ALU_OP_W-1:0] alu_op;
    logic [`GPR_AW-1:0] dest, rf_raddr1, rf_raddr2;

    logic [2:0] mode;
    int vec_idx, num_vecs, cycles, cycle_limit, tests_run, tests_failed;
    logic [31:0] vec [max_vecs][ncols];
    logic [31:0] exp_f [ncols];

    id_stage u_dut (.*);

    id_checker u_checker (
        .clk(clk), .mode(mode), .vec_idx(vec_idx),
        .exp_inst(exp_f[0]), .exp_pc(exp_f[1]), .exp_alu_op(exp_f[13][`ALU_OP_W-1:0]),
        .exp_ctl(exp_f[14][7:0]), .exp_imm(exp_f[15]), .exp_dest(exp_f[16][`GPR_AW-1:0]),
        .exp_rj(exp_f[17]), .exp_rkd(exp_f[18]), .exp_taken(exp_f[19][0]),
        .exp_target(exp_f[20]),
        .id_allow_in(id_allow_in), .id_to_ex_valid(id_to_ex_valid), .id_pc(id_pc),
        .rj_value(rj_value), .rkd_value(rkd_value), .imm(imm), .alu_op(alu_op),
        .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm), .mem_read(mem_read),
        .mem_write(mem_write), .mem_size(mem_size), .mem_signed(mem_signed),
        .dest(dest), .gr_we(gr_we), .br_taken(br_taken), .br_target(br_target),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .tests_run(tests_run), .tests_failed(tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // the limit grows with the number of vectors once the file is read
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic load_vectors();
        int fd;
        int k;
        string line;
        logic [31:0] f [ncols];
        fd = $fopen("verif/id_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/id_stimulus.txt");
            return;
        end
        while (!$feof(fd) && num_vecs < max_vecs) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() <= 8 || line.getc(0) == 8'h23) begin
                continue;
            end
            k = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                        f[19], f[20]);
            if (k == ncols) begin
                vec[num_vecs] = f;
                num_vecs++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input int i);
        int k;
        @(posedge clk);
        #1;
        mode        = 3'd0;
        vec_idx     = i;
        exp_f       = vec[i];
        if_valid    = 1'b1;
        if_inst     = vec[i][0];
        if_pc       = vec[i][1];
        rf_rdata1   = vec[i][2];
        rf_rdata2   = vec[i][3];
        ex_dest     = vec[i][4][`GPR_AW-1:0];
        ex_value    = vec[i][5];
        mem_dest    = vec[i][6][`GPR_AW-1:0];
        mem_value   = vec[i][7];
        wb_dest     = vec[i][8][`GPR_AW-1:0];
        wb_value    = vec[i][9];
        ex_is_load  = vec[i][10][0] && vec[i][11] != 0;
        mem_wait    = vec[i][10][1] && vec[i][11] != 0;
        ex_allow_in = 1'b1;
        @(negedge clk);
        while (!id_allow_in) @(negedge clk);
        @(posedge clk);
        #1;
        if_valid = 1'b0;
        for (k = 0; k < int'(vec[i][11]); k++) begin
            mode = 3'd1;
            @(posedge clk);
            #1;
        end
        ex_is_load = 1'b0;
        mem_wait   = 1'b0;
        for (k = 0; k < int'(vec[i][12]); k++) begin
            mode        = 3'd2;
            ex_allow_in = 1'b0;
            @(posedge clk);
            #1;
        end
        mode        = 3'd3;
        ex_allow_in = 1'b1;
        if_valid    = 1'b1;
        if_inst     = 32'h0340_0000; // andi r0,r0,0 follows as a filler
        if_pc       = vec[i][1] + 32'd4;
        @(posedge clk);
        #1;
        if_valid = 1'b0;
        mode     = 3'd4;
    endtask

    initial begin
        {if_valid, ex_allow_in, ex_is_load, mem_wait} = '0;
        {if_pc, if_inst, rf_rdata1, rf_rdata2, ex_value, mem_value, wb_value} = '0;
        {ex_dest, mem_dest, wb_dest} = '0;
        arst_n      = 1'b0;
        mode        = 3'd0;
        vec_idx     = 0;
        num_vecs    = 0;
        cycles      = 0;
        cycle_limit = 100;
        exp_f       = '{default: '0};
        load_vectors();
        cycle_limit = 8 * num_vecs + 100;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (int i = 0; i < num_vecs; i++) begin
            run_vector(i);
        end
        @(posedge clk);
        #1;
        mode = 3'd0;
        repeat (2) @(posedge clk);
        $display("tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (num_vecs > 0 && tests_run == num_vecs && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/id_stimulus.txt */
# inst pc rdata1 rdata2 ex_dest ex_value mem_dest mem_value wb_dest wb_value haz nstall nbp
# then expected: alu_op ctl{pc,imm,rd,wr,size2,sgn,we} imm dest rj rkd taken target
00102507 1c000000 100 200 0 0 0 0 0 0 0 0 0 001 01 0 7 100 200 0 0
00112507 1c000004 100 200 0 0 8 bbbb 8 cccc 0 0 0 002 01 0 7 bbbb 200 0 0
00122507 1c000008 100 200 9 aaaa 9 bbbb 8 cccc 0 0 0 004 01 0 7 cccc aaaa 0 0
0012a507 1c00000c 100 200 0 0 0 0 0 0 1 2 0 008 01 0 7 100 200 0 0
0014a507 1c000010 100 200 0 0 0 0 0 0 2 1 0 010 01 0 7 100 200 0 0
00142507 1c000014 100 200 0 0 0 0 0 0 0 0 2 020 01 0 7 100 200 0 0
00152507 1c000018 100 200 0 0 0 0 0 0 0 0 0 040 01 0 7 100 200 0 0
0015a507 1c00001c 100 200 0 0 0 0 0 0 0 0 0 080 01 0 7 100 200 0 0
00172507 1c000020 100 200 0 0 0 0 0 0 0 0 0 100 01 0 7 100 200 0 0
00178507 1c000024 100 200 0 0 0 0 0 0 0 0 0 200 01 0 7 100 200 0 0
00182507 1c000028 100 200 0 0 0 0 0 0 0 0 0 400 01 0 7 100 200 0 0
00408d07 1c00002c 100 200 0 0 0 0 0 0 0 0 0 100 41 23 7 100 200 0 0
00448d07 1c000030 100 200 0 0 0 0 0 0 0 0 0 200 41 123 7 100 200 0 0
00488d07 1c000034 100 200 0 0 0 0 0 0 0 0 0 400 41 223 7 100 200 0 0
023ffd07 1c000038 100 200 0 0 0 0 0 0 0 0 0 004 41 ffffffff 7 100 200 0 0
025ffd07 1c00003c 100 200 0 0 0 0 0 0 0 0 0 008 41 7ff 7 100 200 0 0
02a01007 1c000040 100 200 0 dead 1 beef 0 0 0 0 0 001 41 fffff804 7 100 200 0 0
037ffd07 1c000044 100 200 0 0 0 0 0 0 0 0 0 010 41 fff 7 100 200 0 0
03bffd07 1c000048 100 200 0 0 0 0 0 0 0 0 0 040 41 fff 7 100 200 0 0
03fffd07 1c00004c 100 200 0 0 0 0 0 0 0 0 0 080 41 fff 7 100 200 0 0
142468a7 1c000050 100 200 0 0 0 0 0 0 0 0 0 800 41 12345000 7 100 200 0 0
1c2468a7 1c000054 100 200 0 0 0 0 0 0 0 0 0 001 c1 12345000 7 100 200 0 0
28004107 1c000058 100 200 0 0 0 0 0 0 0 0 0 001 63 10 7 100 200 0 0
28404107 1c00005c 100 200 0 0 0 0 0 0 0 0 0 001 67 10 7 100 200 0 0
28804107 1c000060 100 200 0 0 0 0 0 0 0 0 0 001 6b 10 7 100 200 0 0
2a004107 1c000064 100 200 0 0 0 0 0 0 0 0 0 001 61 10 7 100 200 0 0
2a404107 1c000068 100 200 0 0 0 0 0 0 0 0 0 001 65 10 7 100 200 0 0
29004107 1c00006c 100 200 0 0 0 0 0 0 0 0 0 001 50 10 0 100 200 0 0
29404107 1c000070 100 200 0 0 0 0 0 0 0 0 0 001 54 10 0 100 200 0 0
29804107 1c000074 100 200 0 0 0 0 0 0 0 0 0 001 58 10 0 100 200 0 0
58010107 1c000000 5 5 0 0 0 0 0 0 0 0 0 000 00 0 0 5 5 1 1c000100
58010107 1c000000 5 6 0 0 0 0 0 0 0 0 0 000 00 0 0 5 6 0 0
5c010107 1c000000 5 6 0 0 0 0 0 0 1 1 0 000 00 0 0 5 6 1 1c000100
5c010107 1c000000 5 5 0 0 0 0 0 0 0 0 0 000 00 0 0 5 5 0 0
60010107 1c000000 ffffffff 1 0 0 0 0 0 0 0 0 0 000 00 0 0 ffffffff 1 1 1c000100
60010107 1c000000 1 ffffffff 0 0 0 0 0 0 0 0 0 000 00 0 0 1 ffffffff 0 0
64010107 1c000000 1 ffffffff 0 0 0 0 0 0 2 1 0 000 00 0 0 1 ffffffff 1 1c000100
64010107 1c000000 ffffffff 1 0 0 0 0 0 0 0 0 0 000 00 0 0 ffffffff 1 0 0
68010107 1c000000 1 ffffffff 0 0 0 0 0 0 0 0 0 000 00 0 0 1 ffffffff 1 1c000100
68010107 1c000000 ffffffff 1 0 0 0 0 0 0 0 0 0 000 00 0 0 ffffffff 1 0 0
6c010107 1c000000 ffffffff 1 0 0 0 0 0 0 0 0 0 000 00 0 0 ffffffff 1 1 1c000100
6c010107 1c000000 1 ffffffff 0 0 0 0 0 0 0 0 0 000 00 0 0 1 ffffffff 0 0
53fff3ff 1c000000 100 200 0 0 0 0 0 0 0 0 0 000 00 0 0 100 200 1 1bfffff0
54010000 1c000040 100 200 0 0 0 0 0 0 0 0 0 001 c1 4 1 100 200 1 1c000140
4c001101 1c000080 100 200 8 2000 0 0 0 0 0 0 0 001 c1 4 1 2000 200 1 2010

/* src.f */
+incdir+design
design/id_pkg.sv
design/inst_decoder.sv
design/imm_gen.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_stage.sv
verif/id_checker.sv
verif/tb_id_stage.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_id_stage -o tb_id_stage \
    && out="$(./obj_dir/tb_id_stage)" \
    && echo "$out" \
    && echo "$out" | grep -qx "STATUS: PASS" \
    || exit 1
